/* axi_dma.f */
dma_axi_pkg.sv
dma_native_pkg.sv
native_bus_if.sv
dma_read_merge.sv
axi_dma_r.sv
axi_dma_w.sv
axi_dma.sv
axi_mem_model.sv
axi_dma_tb.sv

/* axi_dma.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_dma (
	input wire clk,
	input wire rst_n,

	// Native ports {write, read 1, read 0}
	input wire [dma_native_pkg::N_PORTS-1:0]                                databus_valid,
	input wire [dma_native_pkg::N_PORTS*dma_native_pkg::NATIVE_ADDR_W-1:0] databus_addr,
	input wire [dma_native_pkg::N_PORTS*dma_native_pkg::NATIVE_DATA_W-1:0] databus_wdata,
	input wire [dma_native_pkg::N_PORTS*dma_native_pkg::NATIVE_STRB_W-1:0] databus_wstrb,
	output wire [dma_native_pkg::N_PORTS*dma_native_pkg::NATIVE_DATA_W-1:0] databus_rdata,
	output wire [dma_native_pkg::N_PORTS-1:0]                               databus_ready,

	input wire [dma_native_pkg::BURST_LEN_W-1:0] rd_len,
	input wire [dma_native_pkg::BURST_LEN_W-1:0] wr_len,

	output wire [dma_axi_pkg::AXI_ID_W-1:0]    m_axi_awid,
	output wire [dma_axi_pkg::AXI_ADDR_W-1:0]  m_axi_awaddr,
	output wire [dma_axi_pkg::AXI_LEN_W-1:0]   m_axi_awlen,
	output wire [dma_axi_pkg::AXI_SIZE_W-1:0]  m_axi_awsize,
	output wire [dma_axi_pkg::AXI_BURST_W-1:0] m_axi_awburst,
	output wire [dma_axi_pkg::AXI_LOCK_W-1:0]  m_axi_awlock,
	output wire [dma_axi_pkg::AXI_CACHE_W-1:0] m_axi_awcache,
	output wire [dma_axi_pkg::AXI_PROT_W-1:0]  m_axi_awprot,
	output wire [dma_axi_pkg::AXI_QOS_W-1:0]   m_axi_awqos,
	output wire                                m_axi_awvalid,
	input wire                                 m_axi_awready,

	output wire [dma_axi_pkg::AXI_DATA_W-1:0]  m_axi_wdata,
	output wire [dma_axi_pkg::AXI_STRB_W-1:0]  m_axi_wstrb,
	output wire                                m_axi_wlast,
	output wire                                m_axi_wvalid,
	input wire                                 m_axi_wready,

	input wire [dma_axi_pkg::AXI_RESP_W-1:0]   m_axi_bresp,
	input wire                                 m_axi_bvalid,
	output wire                                m_axi_bready,

	output wire [dma_axi_pkg::AXI_ID_W-1:0]    m_axi_arid,
	output wire [dma_axi_pkg::AXI_ADDR_W-1:0]  m_axi_araddr,
	output wire [dma_axi_pkg::AXI_LEN_W-1:0]   m_axi_arlen,
	output wire [dma_axi_pkg::AXI_SIZE_W-1:0]  m_axi_arsize,
	output wire [dma_axi_pkg::AXI_BURST_W-1:0] m_axi_arburst,
	output wire [dma_axi_pkg::AXI_LOCK_W-1:0]  m_axi_arlock,
	output wire [dma_axi_pkg::AXI_CACHE_W-1:0] m_axi_arcache,
	output wire [dma_axi_pkg::AXI_PROT_W-1:0]  m_axi_arprot,
	output wire [dma_axi_pkg::AXI_QOS_W-1:0]   m_axi_arqos,
	output wire                                m_axi_arvalid,
	input wire                                 m_axi_arready,

	input wire [dma_axi_pkg::AXI_DATA_W-1:0]   m_axi_rdata,
	input wire [dma_axi_pkg::AXI_RESP_W-1:0]   m_axi_rresp,
	input wire                                 m_axi_rlast,
	input wire                                 m_axi_rvalid,
	output wire                                m_axi_rready
);
	import dma_native_pkg::*;

	native_bus_if rd_bus [N_READ_PORTS] ();
	native_bus_if rd_merged ();
	native_bus_if wr_bus ();

	// Read port i sits in slice i
	for (genvar i = 0; i < N_READ_PORTS; i++) begin : g_rd
		assign rd_bus[i].valid = databus_valid[i];
		assign rd_bus[i].addr  = databus_addr[i*NATIVE_ADDR_W +: NATIVE_ADDR_W];
		assign rd_bus[i].wdata = databus_wdata[i*NATIVE_DATA_W +: NATIVE_DATA_W];
		assign rd_bus[i].wstrb = databus_wstrb[i*NATIVE_STRB_W +: NATIVE_STRB_W];
		assign databus_rdata[i*NATIVE_DATA_W +: NATIVE_DATA_W] = rd_bus[i].rdata;
		assign databus_ready[i] = rd_bus[i].ready;
	end

	assign wr_bus.valid = databus_valid[WR_PORT];
	assign wr_bus.addr  = databus_addr[WR_PORT*NATIVE_ADDR_W +: NATIVE_ADDR_W];
	assign wr_bus.wdata = databus_wdata[WR_PORT*NATIVE_DATA_W +: NATIVE_DATA_W];
	assign wr_bus.wstrb = databus_wstrb[WR_PORT*NATIVE_STRB_W +: NATIVE_STRB_W];
	assign databus_rdata[WR_PORT*NATIVE_DATA_W +: NATIVE_DATA_W] = wr_bus.rdata;
	assign databus_ready[WR_PORT] = wr_bus.ready;

	dma_read_merge read_merge_i (
		.clk   (clk),
		.rst_n (rst_n),
		.m     (rd_bus),
		.s     (rd_merged)
	);

	axi_dma_r dma_r_i (
		.bus (rd_merged),
		.*
	);

	axi_dma_w dma_w_i (
		.bus (wr_bus),
		.*
	);

endmodule

`default_nettype wire

/* axi_dma_r.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_dma_r (
	input wire clk,
	input wire rst_n,
	native_bus_if.responder bus,
	input wire [dma_native_pkg::BURST_LEN_W-1:0] rd_len,

	output logic [dma_axi_pkg::AXI_ID_W-1:0]    m_axi_arid,
	output logic [dma_axi_pkg::AXI_ADDR_W-1:0]  m_axi_araddr,
	output logic [dma_axi_pkg::AXI_LEN_W-1:0]   m_axi_arlen,
	output logic [dma_axi_pkg::AXI_SIZE_W-1:0]  m_axi_arsize,
	output dma_axi_pkg::axi_burst_e             m_axi_arburst,
	output logic [dma_axi_pkg::AXI_LOCK_W-1:0]  m_axi_arlock,
	output logic [dma_axi_pkg::AXI_CACHE_W-1:0] m_axi_arcache,
	output logic [dma_axi_pkg::AXI_PROT_W-1:0]  m_axi_arprot,
	output logic [dma_axi_pkg::AXI_QOS_W-1:0]   m_axi_arqos,
	output logic                                m_axi_arvalid,
	input wire                                  m_axi_arready,

	input wire [dma_axi_pkg::AXI_DATA_W-1:0]    m_axi_rdata,
	input wire [dma_axi_pkg::AXI_RESP_W-1:0]    m_axi_rresp,
	input wire                                  m_axi_rlast,
	input wire                                  m_axi_rvalid,
	output logic                                m_axi_rready
);
	import dma_native_pkg::*;
	import dma_axi_pkg::*;

	rd_state_e                state_q;
	logic [NATIVE_DATA_W-1:0] buf_mem [MAX_BURST];
	logic [BEAT_CNT_W-1:0]    wr_cnt_q;
	logic [BEAT_CNT_W-1:0]    rd_cnt_q;
	logic [NATIVE_ADDR_W-1:0] next_addr_q;
	logic [AXI_ADDR_W-1:0]    araddr_q;
	logic [AXI_LEN_W-1:0]     arlen_q;
	logic                     ready_q;
	logic [NATIVE_DATA_W-1:0] rdata_q;
	logic                     req;
	logic                     hit;
	logic                     beat;
	logic                     accept;

	// Valid stays high during the ready cycle, which must not count twice
	assign req    = bus.valid && !ready_q;
	assign accept = req && (state_q == RD_IDLE || state_q == RD_SERVE);
	assign hit    = state_q == RD_SERVE && bus.addr == next_addr_q && rd_cnt_q != wr_cnt_q;
	assign beat   = m_axi_rvalid && m_axi_rready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q  <= RD_IDLE;
			ready_q  <= 1'b0;
			wr_cnt_q <= '0;
			rd_cnt_q <= '0;
		end else begin
			ready_q <= 1'b0;
			case (state_q)
				RD_IDLE, RD_SERVE: begin
					if (accept && hit) begin
						ready_q  <= 1'b1;
						rd_cnt_q <= rd_cnt_q + BEAT_CNT_W'(1);
						if (rd_cnt_q + BEAT_CNT_W'(1) == wr_cnt_q) begin
							state_q <= RD_IDLE;
						end
					end else if (accept) begin
						// Miss drops whatever is left in the buffer
						state_q  <= RD_ADDR;
						wr_cnt_q <= '0;
						rd_cnt_q <= '0;
					end
				end
				RD_ADDR: begin
					if (m_axi_arready) begin
						state_q <= RD_FILL;
					end
				end
				RD_FILL: begin
					if (beat) begin
						wr_cnt_q <= wr_cnt_q + BEAT_CNT_W'(1);
						// First beat answers the pending request
						if (wr_cnt_q == '0) begin
							ready_q  <= 1'b1;
							rd_cnt_q <= BEAT_CNT_W'(1);
						end
						if (m_axi_rlast) begin
							state_q <= (wr_cnt_q == '0) ? RD_IDLE : RD_SERVE;
						end
					end
				end
				default: state_q <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept && hit) begin
			rdata_q     <= buf_mem[rd_cnt_q[BUF_AW-1:0]];
			next_addr_q <= next_addr_q + NATIVE_ADDR_W'(NATIVE_STRB_W);
		end else if (accept) begin
			araddr_q    <= bus.addr;
			arlen_q     <= AXI_LEN_W'(rd_len);
			next_addr_q <= bus.addr + NATIVE_ADDR_W'(NATIVE_STRB_W);
		end
		if (state_q == RD_FILL && beat) begin
			buf_mem[wr_cnt_q[BUF_AW-1:0]] <= m_axi_rdata;
			if (wr_cnt_q == '0) begin
				rdata_q <= m_axi_rdata;
			end
		end
	end

	assign m_axi_arid    = AXI_ID_VAL;
	assign m_axi_araddr  = araddr_q;
	assign m_axi_arlen   = arlen_q;
	assign m_axi_arsize  = AXI_SIZE_FULL;
	assign m_axi_arburst = BURST_INCR;
	assign m_axi_arlock  = AXI_LOCK_VAL;
	assign m_axi_arcache = AXI_CACHE_VAL;
	assign m_axi_arprot  = AXI_PROT_VAL;
	assign m_axi_arqos   = AXI_QOS_VAL;
	assign m_axi_arvalid = state_q == RD_ADDR;
	assign m_axi_rready  = state_q == RD_FILL;

	assign bus.ready = ready_q;
	assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

/* axi_dma_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_dma_tb;
	import dma_axi_pkg::*;
	import dma_native_pkg::*;

	localparam int          TIMEOUT_CYC = 2000;
	localparam logic [31:0] FILL_KEY    = 32'hA5A5_0000;

	logic clk = 1'b0;
	logic rst_n;
	logic refill;

	logic [N_PORTS-1:0]               databus_valid;
	logic [N_PORTS*NATIVE_ADDR_W-1:0] databus_addr;
	logic [N_PORTS*NATIVE_DATA_W-1:0] databus_wdata;
	logic [N_PORTS*NATIVE_STRB_W-1:0] databus_wstrb;
	logic [N_PORTS*NATIVE_DATA_W-1:0] databus_rdata;
	logic [N_PORTS-1:0]               databus_ready;
	logic [BURST_LEN_W-1:0]           rd_len;
	logic [BURST_LEN_W-1:0]           wr_len;

	logic [AXI_ID_W-1:0]    m_axi_awid, m_axi_arid;
	logic [AXI_ADDR_W-1:0]  m_axi_awaddr, m_axi_araddr;
	logic [AXI_LEN_W-1:0]   m_axi_awlen, m_axi_arlen;
	logic [AXI_SIZE_W-1:0]  m_axi_awsize, m_axi_arsize;
	logic [AXI_BURST_W-1:0] m_axi_awburst, m_axi_arburst;
	logic [AXI_LOCK_W-1:0]  m_axi_awlock, m_axi_arlock;
	logic [AXI_CACHE_W-1:0] m_axi_awcache, m_axi_arcache;
	logic [AXI_PROT_W-1:0]  m_axi_awprot, m_axi_arprot;
	logic [AXI_QOS_W-1:0]   m_axi_awqos, m_axi_arqos;
	logic [AXI_DATA_W-1:0]  m_axi_wdata, m_axi_rdata;
	logic [AXI_STRB_W-1:0]  m_axi_wstrb;
	logic [AXI_RESP_W-1:0]  m_axi_bresp, m_axi_rresp;
	logic m_axi_awvalid, m_axi_awready, m_axi_wlast, m_axi_wvalid, m_axi_wready;
	logic m_axi_bvalid, m_axi_bready, m_axi_arvalid, m_axi_arready;
	logic m_axi_rlast, m_axi_rvalid, m_axi_rready;

	int err_count  = 0;
	int test_count = 0;
	int bad_tests  = 0;
	bit abort_run  = 1'b0;

	always #20 clk = ~clk;

	axi_dma axi_dma_i (.*);

	axi_mem_model #(.WORDS(1024), .FILL_KEY(FILL_KEY), .SEED(47105)) mem_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.refill  (refill),
		.awaddr  (m_axi_awaddr),
		.awlen   (m_axi_awlen),
		.awvalid (m_axi_awvalid),
		.awready (m_axi_awready),
		.wdata   (m_axi_wdata),
		.wstrb   (m_axi_wstrb),
		.wlast   (m_axi_wlast),
		.wvalid  (m_axi_wvalid),
		.wready  (m_axi_wready),
		.bresp   (m_axi_bresp),
		.bvalid  (m_axi_bvalid),
		.bready  (m_axi_bready),
		.araddr  (m_axi_araddr),
		.arlen   (m_axi_arlen),
		.arvalid (m_axi_arvalid),
		.arready (m_axi_arready),
		.rdata   (m_axi_rdata),
		.rresp   (m_axi_rresp),
		.rlast   (m_axi_rlast),
		.rvalid  (m_axi_rvalid),
		.rready  (m_axi_rready)
	);

	// Memory content right after a refill
	function automatic logic [AXI_DATA_W-1:0] preload_value(input logic [31:0] addr);
		return addr ^ FILL_KEY;
	endfunction

	function automatic logic [AXI_DATA_W-1:0] merge_bytes(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [AXI_STRB_W-1:0] strb);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < AXI_STRB_W; b++) begin
			if (strb[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	task automatic check_word(input string what, input logic [AXI_DATA_W-1:0] got,
			input logic [AXI_DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s gave %h, expected %h", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic check_len(input string what, input logic [AXI_LEN_W-1:0] got,
			input logic [AXI_LEN_W-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("MISMATCH at %0t ns: %s counted %0d, expected %0d", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			err_count++;
		end
	endtask

	// Full-width INCR beats of 4 bytes with ID zero and the fixed attributes
	task automatic check_sideband(input string chan, input logic [AXI_ID_W-1:0] id,
			input logic [AXI_SIZE_W-1:0] size, input logic [AXI_BURST_W-1:0] burst,
			input logic [AXI_LOCK_W-1:0] lock, input logic [AXI_CACHE_W-1:0] cache,
			input logic [AXI_PROT_W-1:0] prot, input logic [AXI_QOS_W-1:0] qos);
		if (id !== '0 || size !== 3'd2 || burst !== 2'b01 || lock !== AXI_LOCK_VAL
				|| cache !== AXI_CACHE_VAL || prot !== AXI_PROT_VAL
				|| qos !== AXI_QOS_VAL) begin
			$display("MISMATCH at %0t ns: %s side-band id %h size %h burst %h lock %h %s",
				$time, chan, id, size, burst, lock, "or attributes wrong");
			err_count++;
		end
	endtask

	always @(negedge clk) begin
		if (rst_n === 1'b1 && m_axi_arvalid === 1'b1) begin
			check_sideband("AR", m_axi_arid, m_axi_arsize, m_axi_arburst, m_axi_arlock,
				m_axi_arcache, m_axi_arprot, m_axi_arqos);
		end
		if (rst_n === 1'b1 && m_axi_awvalid === 1'b1) begin
			check_sideband("AW", m_axi_awid, m_axi_awsize, m_axi_awburst, m_axi_awlock,
				m_axi_awcache, m_axi_awprot, m_axi_awqos);
		end
	end

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		if (err_count == errs_before) begin
			$display("%-18s ok", name);
		end else begin
			bad_tests++;
			$display("%-18s FAILED with %0d errors", name, err_count - errs_before);
		end
	endtask

	// Checks ready mid-cycle, so a handshake completes on the next edge
	task automatic wait_ready(input int port, output bit ok);
		ok = 1'b0;
		for (int n = 0; n < TIMEOUT_CYC && !ok; n++) begin
			@(negedge clk);
			ok = databus_ready[port];
		end
		if (!ok) begin
			$display("ERROR at %0t ns: port %0d got no ready within %0d cycles",
				$time, port, TIMEOUT_CYC);
			err_count++;
			abort_run = 1'b1;
		end
	endtask

	task automatic read_word(input int port, input logic [31:0] addr,
			output logic [AXI_DATA_W-1:0] data);
		bit ok;
		data = '0;
		if (abort_run) begin
			return;
		end
		databus_addr[port*NATIVE_ADDR_W +: NATIVE_ADDR_W] = addr;
		databus_valid[port] = 1'b1;
		wait_ready(port, ok);
		if (ok) begin
			data = databus_rdata[port*NATIVE_DATA_W +: NATIVE_DATA_W];
		end
		@(posedge clk);
		#2;
		databus_valid[port] = 1'b0;
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
			input logic [NATIVE_STRB_W-1:0] strb);
		bit ok;
		if (abort_run) begin
			return;
		end
		databus_addr[WR_PORT*NATIVE_ADDR_W +: NATIVE_ADDR_W]  = addr;
		databus_wdata[WR_PORT*NATIVE_DATA_W +: NATIVE_DATA_W] = data;
		databus_wstrb[WR_PORT*NATIVE_STRB_W +: NATIVE_STRB_W] = strb;
		databus_valid[WR_PORT] = 1'b1;
		wait_ready(WR_PORT, ok);
		@(posedge clk);
		#2;
		databus_valid[WR_PORT] = 1'b0;
	endtask

	task automatic read_check(input int port, input logic [31:0] addr);
		logic [AXI_DATA_W-1:0] got;
		read_word(port, addr, got);
		if (!abort_run) begin
			check_word($sformatf("port %0d read at %h", port, addr), got, preload_value(addr));
		end
	endtask

	task automatic read_seq(input int port, input logic [31:0] base, input int words);
		for (int k = 0; k < words; k++) begin
			read_check(port, base + 32'(4 * k));
		end
	endtask

	// Fresh memory image and burst lengths for the next test
	task automatic prepare(input logic [BURST_LEN_W-1:0] rlen, input logic [BURST_LEN_W-1:0] wlen);
		rd_len = rlen;
		wr_len = wlen;
		refill = 1'b1;
		@(posedge clk);
		#2;
		refill = 1'b0;
	endtask

	task automatic idle_after_reset();
		int errs;
		errs = err_count;
		@(negedge clk);
		check_bit("arvalid", m_axi_arvalid, 1'b0);
		check_bit("awvalid", m_axi_awvalid, 1'b0);
		check_bit("wvalid", m_axi_wvalid, 1'b0);
		check_bit("bready", m_axi_bready, 1'b0);
		check_bit("rready", m_axi_rready, 1'b0);
		for (int p = 0; p < N_PORTS; p++) begin
			check_bit($sformatf("databus_ready[%0d]", p), databus_ready[p], 1'b0);
		end
		@(posedge clk);
		#2;
		report_test("idle_after_reset", errs);
	endtask

	task automatic sequential_read();
		int errs;
		errs = err_count;
		prepare(BURST_LEN_W'(3), BURST_LEN_W'(0));
		read_seq(0, 32'h0, 12);
		check_count("AR handshakes", mem_i.ar_count, 3);
		for (int k = 0; k < 3; k++) begin
			check_len($sformatf("arlen of burst %0d", k), mem_i.arlen_log[k], AXI_LEN_W'(3));
		end
		report_test("sequential_read", errs);
	endtask

	task automatic jump_read();
		int errs;
		errs = err_count;
		prepare(BURST_LEN_W'(7), BURST_LEN_W'(0));
		read_check(0, 32'd0);
		read_check(0, 32'd4);
		read_check(0, 32'd40);
		check_count("AR handshakes", mem_i.ar_count, 2);
		check_len("arlen of burst 0", mem_i.arlen_log[0], AXI_LEN_W'(7));
		check_len("arlen of burst 1", mem_i.arlen_log[1], AXI_LEN_W'(7));
		report_test("jump_read", errs);
	endtask

	task automatic shared_read();
		int errs;
		errs = err_count;
		prepare(BURST_LEN_W'(3), BURST_LEN_W'(0));
		fork
			read_seq(0, 32'h080, 8);
			read_seq(1, 32'h300, 8);
		join
		report_test("shared_read", errs);
	endtask

	task automatic burst_write();
		int                    errs;
		logic [AXI_DATA_W-1:0] got;
		errs = err_count;
		prepare(BURST_LEN_W'(3), BURST_LEN_W'(3));
		for (int k = 0; k < 4; k++) begin
			write_word(32'd256 + 32'(4 * k), 32'hC0DE_0000 | 32'(k), 4'hF);
		end
		check_count("AW handshakes", mem_i.aw_count, 1);
		check_len("awlen", mem_i.awlen_last, AXI_LEN_W'(3));
		check_count("beats with wlast", mem_i.wlast_count, 1);
		check_count("beat number with wlast", mem_i.wlast_beat, 4);
		for (int k = 0; k < 4; k++) begin
			read_word(0, 32'd256 + 32'(4 * k), got);
			check_word($sformatf("readback %0d", k), got, 32'hC0DE_0000 | 32'(k));
		end
		report_test("burst_write", errs);
	endtask

	task automatic strobe_write();
		int                    errs;
		logic [AXI_DATA_W-1:0] got;
		errs = err_count;
		prepare(BURST_LEN_W'(1), BURST_LEN_W'(1));
		write_word(32'd512, 32'h1122_3344, 4'b0101);
		write_word(32'd516, 32'h5566_7788, 4'b1010);
		check_len("awlen", mem_i.awlen_last, AXI_LEN_W'(1));
		read_word(1, 32'd512, got);
		check_word("strobed word 512", got,
			merge_bytes(preload_value(32'd512), 32'h1122_3344, 4'b0101));
		read_word(1, 32'd516, got);
		check_word("strobed word 516", got,
			merge_bytes(preload_value(32'd516), 32'h5566_7788, 4'b1010));
		report_test("strobe_write", errs);
	endtask

	initial begin
		rst_n         = 1'b0;
		refill        = 1'b0;
		databus_valid = '0;
		databus_addr  = '0;
		databus_wdata = '0;
		databus_wstrb = '0;
		rd_len        = '0;
		wr_len        = '0;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;

		idle_after_reset();
		sequential_read();
		jump_read();
		shared_read();
		burst_write();
		strobe_write();

		$display("Summary: %0d tests, %0d with errors, %0d errors in total",
			test_count, bad_tests, err_count);
		if (err_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* axi_dma_w.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_dma_w (
	input wire clk,
	input wire rst_n,
	native_bus_if.responder bus,
	input wire [dma_native_pkg::BURST_LEN_W-1:0] wr_len,

	output logic [dma_axi_pkg::AXI_ID_W-1:0]    m_axi_awid,
	output logic [dma_axi_pkg::AXI_ADDR_W-1:0]  m_axi_awaddr,
	output logic [dma_axi_pkg::AXI_LEN_W-1:0]   m_axi_awlen,
	output logic [dma_axi_pkg::AXI_SIZE_W-1:0]  m_axi_awsize,
	output dma_axi_pkg::axi_burst_e             m_axi_awburst,
	output logic [dma_axi_pkg::AXI_LOCK_W-1:0]  m_axi_awlock,
	output logic [dma_axi_pkg::AXI_CACHE_W-1:0] m_axi_awcache,
	output logic [dma_axi_pkg::AXI_PROT_W-1:0]  m_axi_awprot,
	output logic [dma_axi_pkg::AXI_QOS_W-1:0]   m_axi_awqos,
	output logic                                m_axi_awvalid,
	input wire                                  m_axi_awready,

	output logic [dma_axi_pkg::AXI_DATA_W-1:0]  m_axi_wdata,
	output logic [dma_axi_pkg::AXI_STRB_W-1:0]  m_axi_wstrb,
	output logic                                m_axi_wlast,
	output logic                                m_axi_wvalid,
	input wire                                  m_axi_wready,

	input wire [dma_axi_pkg::AXI_RESP_W-1:0]    m_axi_bresp,
	input wire                                  m_axi_bvalid,
	output logic                                m_axi_bready
);
	import dma_native_pkg::*;
	import dma_axi_pkg::*;

	wr_state_e             state_q;
	logic [AXI_ADDR_W-1:0] awaddr_q;
	logic [AXI_LEN_W-1:0]  awlen_q;
	logic [AXI_LEN_W-1:0]  beat_q;
	logic                  w_hs;

	assign w_hs = m_axi_wvalid && m_axi_wready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= WR_IDLE;
			beat_q  <= '0;
		end else begin
			case (state_q)
				WR_IDLE: begin
					// First write opens the burst but is acked in DATA
					if (bus.valid) begin
						state_q <= WR_ADDR;
						beat_q  <= '0;
					end
				end
				WR_ADDR: begin
					if (m_axi_awready) begin
						state_q <= WR_DATA;
					end
				end
				WR_DATA: begin
					if (w_hs) begin
						beat_q <= beat_q + AXI_LEN_W'(1);
						if (m_axi_wlast) begin
							state_q <= WR_RESP;
						end
					end
				end
				WR_RESP: begin
					if (m_axi_bvalid) begin
						state_q <= WR_IDLE;
					end
				end
				default: state_q <= WR_IDLE;
			endcase
		end
	end

	// Burst address and length from the first write only
	always_ff @(posedge clk) begin
		if (state_q == WR_IDLE && bus.valid) begin
			awaddr_q <= bus.addr;
			awlen_q  <= AXI_LEN_W'(wr_len);
		end
	end

	assign m_axi_awid    = AXI_ID_VAL;
	assign m_axi_awaddr  = awaddr_q;
	assign m_axi_awlen   = awlen_q;
	assign m_axi_awsize  = AXI_SIZE_FULL;
	assign m_axi_awburst = BURST_INCR;
	assign m_axi_awlock  = AXI_LOCK_VAL;
	assign m_axi_awcache = AXI_CACHE_VAL;
	assign m_axi_awprot  = AXI_PROT_VAL;
	assign m_axi_awqos   = AXI_QOS_VAL;
	assign m_axi_awvalid = state_q == WR_ADDR;

	// Native writes pass straight through as W beats
	assign m_axi_wvalid = state_q == WR_DATA && bus.valid;
	assign m_axi_wdata  = bus.wdata;
	assign m_axi_wstrb  = bus.wstrb;
	assign m_axi_wlast  = beat_q == awlen_q;
	assign m_axi_bready = state_q == WR_RESP;

	assign bus.ready = w_hs;
	// Write port carries no read data
	assign bus.rdata = '0;

endmodule

`default_nettype wire

/* axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

// AXI4 slave memory for the testbench, every channel stalls at random
module axi_mem_model #(
	parameter int          WORDS    = 1024,
	parameter logic [31:0] FILL_KEY = 32'hA5A5_0000,
	parameter int          SEED     = 1
) (
	input wire clk,
	input wire rst_n,
	// Reloads the preload pattern and clears the counters
	input wire refill,

	input wire [dma_axi_pkg::AXI_ADDR_W-1:0]   awaddr,
	input wire [dma_axi_pkg::AXI_LEN_W-1:0]    awlen,
	input wire                                 awvalid,
	output logic                               awready,
	input wire [dma_axi_pkg::AXI_DATA_W-1:0]   wdata,
	input wire [dma_axi_pkg::AXI_STRB_W-1:0]   wstrb,
	input wire                                 wlast,
	input wire                                 wvalid,
	output logic                               wready,
	output logic [dma_axi_pkg::AXI_RESP_W-1:0] bresp,
	output logic                               bvalid,
	input wire                                 bready,
	input wire [dma_axi_pkg::AXI_ADDR_W-1:0]   araddr,
	input wire [dma_axi_pkg::AXI_LEN_W-1:0]    arlen,
	input wire                                 arvalid,
	output logic                               arready,
	output logic [dma_axi_pkg::AXI_DATA_W-1:0] rdata,
	output logic [dma_axi_pkg::AXI_RESP_W-1:0] rresp,
	output logic                               rlast,
	output logic                               rvalid,
	input wire                                 rready
);
	import dma_axi_pkg::*;

	localparam int IDX_W = $clog2(WORDS);

	logic [AXI_DATA_W-1:0] mem [WORDS];
	logic [IDX_W-1:0]      rd_idx;
	logic [AXI_LEN_W-1:0]  rd_left;
	logic                  rd_busy;
	logic [IDX_W-1:0]      wr_idx;
	logic                  wr_busy;
	logic                  b_due;
	integer                seed = SEED;

	// Bookkeeping that the testbench reads
	int                   ar_count;
	int                   aw_count;
	logic [AXI_LEN_W-1:0] arlen_log [8];
	logic [AXI_LEN_W-1:0] awlen_last;
	int                   w_beats;
	int                   wlast_count;
	int                   wlast_beat;

	always @(posedge clk) begin : seq
		logic [31:0] rnd;
		rnd = $random(seed);
		if (!rst_n) begin
			arready     <= 1'b0;
			rvalid      <= 1'b0;
			rd_busy     <= 1'b0;
			awready     <= 1'b0;
			wready      <= 1'b0;
			bvalid      <= 1'b0;
			wr_busy     <= 1'b0;
			b_due       <= 1'b0;
			ar_count    <= 0;
			aw_count    <= 0;
			wlast_count <= 0;
		end else if (refill) begin
			// Word at byte address a holds a ^ FILL_KEY
			for (int i = 0; i < WORDS; i++) begin
				mem[i] <= (32'(i) << 2) ^ FILL_KEY;
			end
			ar_count    <= 0;
			aw_count    <= 0;
			wlast_count <= 0;
			wlast_beat  <= 0;
		end else begin
			// One burst in flight per direction
			if (arvalid && arready) begin
				arready                  <= 1'b0;
				rd_busy                  <= 1'b1;
				rd_idx                   <= araddr[IDX_W+1:2];
				rd_left                  <= arlen;
				arlen_log[ar_count[2:0]] <= arlen;
				ar_count                 <= ar_count + 1;
			end else begin
				arready <= !rd_busy && rnd[1:0] != 2'b00;
			end

			if (rvalid && rready) begin
				if (rlast) begin
					rvalid  <= 1'b0;
					rd_busy <= 1'b0;
				end else begin
					rd_idx  <= rd_idx + 1'b1;
					rd_left <= rd_left - 1'b1;
					rvalid  <= rnd[3:2] != 2'b00;
				end
			end else if (rd_busy && !rvalid) begin
				rvalid <= rnd[3:2] != 2'b00;
			end

			if (awvalid && awready) begin
				awready    <= 1'b0;
				wr_busy    <= 1'b1;
				wr_idx     <= awaddr[IDX_W+1:2];
				awlen_last <= awlen;
				aw_count   <= aw_count + 1;
				w_beats    <= 0;
			end else begin
				awready <= !wr_busy && rnd[5:4] != 2'b00;
			end

			if (wvalid && wready) begin
				for (int b = 0; b < AXI_STRB_W; b++) begin
					if (wstrb[b]) begin
						mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
					end
				end
				wr_idx  <= wr_idx + 1'b1;
				w_beats <= w_beats + 1;
				if (wlast) begin
					wlast_count <= wlast_count + 1;
					wlast_beat  <= w_beats + 1;
					b_due       <= 1'b1;
				end
			end
			// No more W beats once the last one is in
			wready <= wr_busy && !b_due && !(wvalid && wready && wlast) && rnd[7:6] != 2'b00;

			if (bvalid && bready) begin
				bvalid  <= 1'b0;
				b_due   <= 1'b0;
				wr_busy <= 1'b0;
			end else if (b_due && !bvalid) begin
				bvalid <= rnd[9:8] != 2'b00;
			end
		end
	end

	assign rdata = mem[rd_idx];
	assign rlast = rd_busy && rd_left == '0;
	assign rresp = RESP_OKAY;
	assign bresp = RESP_OKAY;

endmodule

`default_nettype wire

/* dma_axi_pkg.sv */
`default_nettype none

package dma_axi_pkg;

	// Bus widths
	localparam int AXI_ADDR_W  = 32;
	localparam int AXI_DATA_W  = 32;
	localparam int AXI_STRB_W  = AXI_DATA_W / 8;
	localparam int AXI_LEN_W   = 8;
	localparam int AXI_SIZE_W  = 3;
	localparam int AXI_BURST_W = 2;
	localparam int AXI_RESP_W  = 2;

	// Side-band widths, AXI4 lock is a single bit
	localparam int AXI_ID_W    = 1;
	localparam int AXI_LOCK_W  = 1;
	localparam int AXI_CACHE_W = 4;
	localparam int AXI_PROT_W  = 3;
	localparam int AXI_QOS_W   = 4;

	// Every beat uses the whole data bus
	localparam logic [AXI_SIZE_W-1:0] AXI_SIZE_FULL = AXI_SIZE_W'($clog2(AXI_STRB_W));

	typedef enum logic [AXI_BURST_W-1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} axi_burst_e;

	typedef enum logic [AXI_RESP_W-1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_e;

	// Fixed side-band values, normal non-cacheable bufferable access
	localparam logic [AXI_ID_W-1:0]    AXI_ID_VAL    = '0;
	localparam logic [AXI_LOCK_W-1:0]  AXI_LOCK_VAL  = 1'b0;
	localparam logic [AXI_CACHE_W-1:0] AXI_CACHE_VAL = 4'b0011;
	localparam logic [AXI_PROT_W-1:0]  AXI_PROT_VAL  = 3'b000;
	localparam logic [AXI_QOS_W-1:0]   AXI_QOS_VAL   = 4'h0;

endpackage

`default_nettype wire

/* dma_native_pkg.sv */
`default_nettype none

package dma_native_pkg;

	// Native data bus
	localparam int NATIVE_ADDR_W = 32;
	localparam int NATIVE_DATA_W = 32;
	localparam int NATIVE_STRB_W = NATIVE_DATA_W / 8;

	// Port layout, write port sits above the read ports
	localparam int N_READ_PORTS = 2;
	localparam int N_PORTS      = N_READ_PORTS + 1;
	localparam int WR_PORT      = N_READ_PORTS;
	localparam int PORT_IDX_W   = (N_READ_PORTS > 1) ? $clog2(N_READ_PORTS) : 1;

	// Burst length limits
	localparam int BURST_LEN_W = 4;
	localparam int MAX_BURST   = 16;
	localparam int BUF_AW      = $clog2(MAX_BURST);
	localparam int BEAT_CNT_W  = $clog2(MAX_BURST + 1);

	typedef enum logic [1:0] {
		RD_IDLE, RD_ADDR, RD_FILL, RD_SERVE
	} rd_state_e;

	typedef enum logic [1:0] {
		WR_IDLE, WR_ADDR, WR_DATA, WR_RESP
	} wr_state_e;

endpackage

`default_nettype wire

/* dma_read_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_read_merge (
	input wire clk,
	input wire rst_n,
	native_bus_if.responder m [dma_native_pkg::N_READ_PORTS],
	native_bus_if.requester s
);
	import dma_native_pkg::*;

	logic [N_READ_PORTS-1:0]  req_valid;
	logic [NATIVE_ADDR_W-1:0] req_addr  [N_READ_PORTS];
	logic [NATIVE_DATA_W-1:0] req_wdata [N_READ_PORTS];
	logic [NATIVE_STRB_W-1:0] req_wstrb [N_READ_PORTS];

	logic                  busy_q;
	logic [PORT_IDX_W-1:0] sel_q;
	logic [PORT_IDX_W-1:0] prio_q;
	logic [PORT_IDX_W-1:0] pick;

	// Interface arrays need constant indices, so gather the ports here
	for (genvar i = 0; i < N_READ_PORTS; i++) begin : g_port
		assign req_valid[i] = m[i].valid;
		assign req_addr[i]  = m[i].addr;
		assign req_wdata[i] = m[i].wdata;
		assign req_wstrb[i] = m[i].wstrb;

		// Only the granted port sees the response
		assign m[i].rdata = (busy_q && sel_q == PORT_IDX_W'(i)) ? s.rdata : '0;
		assign m[i].ready = busy_q && (sel_q == PORT_IDX_W'(i)) && s.ready;
	end

	// First requester at or after the priority pointer
	always_comb begin
		pick = prio_q;
		for (int k = N_READ_PORTS - 1; k >= 0; k--) begin
			if (req_valid[(int'(prio_q) + k) % N_READ_PORTS]) begin
				pick = PORT_IDX_W'((int'(prio_q) + k) % N_READ_PORTS);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			sel_q  <= '0;
			prio_q <= '0;
		end else if (!busy_q) begin
			if (|req_valid) begin
				busy_q <= 1'b1;
				sel_q  <= pick;
			end
		end else if (s.ready) begin
			// Pass priority to the port after the one just served
			busy_q <= 1'b0;
			prio_q <= PORT_IDX_W'((int'(sel_q) + 1) % N_READ_PORTS);
		end
	end

	assign s.valid = busy_q && req_valid[sel_q];
	assign s.addr  = req_addr[sel_q];
	assign s.wdata = req_wdata[sel_q];
	assign s.wstrb = req_wstrb[sel_q];

endmodule

`default_nettype wire

/* native_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One native memory port, valid held until a single-cycle ready
interface native_bus_if;
	import dma_native_pkg::*;

	logic                     valid;
	logic [NATIVE_ADDR_W-1:0] addr;
	logic [NATIVE_DATA_W-1:0] wdata;
	logic [NATIVE_STRB_W-1:0] wstrb;
	logic [NATIVE_DATA_W-1:0] rdata;
	logic                     ready;

	modport requester (
		output valid, addr, wdata, wstrb,
		input  rdata, ready
	);

	modport responder (
		input  valid, addr, wdata, wstrb,
		output rdata, ready
	);

endinterface

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module axi_dma_tb \
	-f axi_dma.f -o axi_dma_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/axi_dma_sim > sim.log 2>&1
cat sim.log
grep -qx "Testbench passed" sim.log && exit 0 || exit 1
